// ==== common/bus_pkg.sv ====
/*
 * Bus-side types of the instruction prefetch unit.
 * Read requests and read responses of the instruction bus.
 */
package bus_pkg;

  // Read request, accepted on valid and ready
  typedef struct packed {
    // Word address to read
    logic [31:0] addr;
  } bus_req_t;

  // Read response, returned in request order
  typedef struct packed {
    // Read data, one instruction word
    logic [31:0] rdata;
  } bus_rsp_t;

endpackage

// ==== common/fetch_pkg.sv ====
/*
 * Core-side types of the instruction prefetch unit.
 * Modules take them through a wildcard import in the module header.
 */
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Address and instruction word width, the core is fixed at 32 bits
  localparam int ADDR_W = 32;

  //////////////////////////////////////////////////////////////////////
  // Controller state and fetch output
  //////////////////////////////////////////////////////////////////////

  // Prefetch controller state
  typedef enum logic [1:0] {
    // Sequential fetching, or waiting for enable / credit
    IDLE        = 2'b00,
    // Branch target held until the bus accepts it
    BRANCH_WAIT = 2'b01
  } prefetch_state_e;

  // Instruction word handed over to the fetch stage
  typedef struct packed {
    // Word address of the instruction
    logic [ADDR_W-1:0] addr;
    // Raw instruction word from the bus
    logic [ADDR_W-1:0] instr;
  } fetch_out_t;

endpackage

// ==== compile.f ====
common/fetch_pkg.sv
common/bus_pkg.sv
prefetcher/prefetch_controller.sv
prefetcher/prefetch_buffer.sv
source/bus_resp_tracker.sv
source/prefetch_unit.sv
test/tb_bus_model.sv
test/tb_prefetch_unit.sv

// ==== prefetcher/prefetch_buffer.sv ====
/*
 * Prefetch FIFO between the response tracker and the fetch stage.
 * Words are written one cycle before they show on the output;
 * a flush empties it. The occupancy count feeds request credit.
 */
`timescale 1ns/10ps

module prefetch_buffer import fetch_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int CNT_W      = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  // Write side from the tracker
  input  logic             wr_valid_i,
  input  fetch_out_t       wr_data_i,
  // Read side to the fetch stage
  output logic             rd_valid_o,
  input  logic             rd_ready_i,
  output fetch_out_t       rd_data_o,
  // Occupancy
  output logic [CNT_W-1:0] count_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  fetch_out_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_en;
  logic             rd_en;

  // Writes during a flush belong to the old stream
  assign wr_en = wr_valid_i && !flush_i;
  assign rd_en = rd_valid_o && rd_ready_i;

  // Head entry is a register, so data holds while not taken
  assign rd_valid_o = count_q != '0;
  assign rd_data_o  = mem[rd_ptr_q];
  assign count_o    = count_q;

  // Payload storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointers and count, wrap at FIFO_DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

endmodule

// ==== prefetcher/prefetch_controller.sv ====
/*
 * Prefetch request FSM. Turns a taken branch into a bus read of the
 * target, then streams reads at the last accepted address plus 4 as
 * long as buffer credit allows. Also signals accepts and flushes.
 */
`timescale 1ns/10ps

module prefetch_controller import fetch_pkg::*, bus_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int CNT_W      = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // Fetch stage control
  input  logic              fetch_en_i,
  input  logic              branch_i,
  input  logic [ADDR_W-1:0] branch_addr_i,
  // Bus read request
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  output bus_req_t          bus_req_o,
  // Credit inputs from tracker and buffer
  input  logic [CNT_W-1:0]  outstanding_cnt_i,
  input  logic [CNT_W-1:0]  buf_count_i,
  // Request accepted / stream redirected
  output logic              req_fire_o,
  output logic              flush_o
);

  prefetch_state_e   state_q;
  prefetch_state_e   state_d;
  logic [ADDR_W-1:0] last_addr_q;
  logic [ADDR_W-1:0] held_addr_q;
  logic              started_q;
  logic [CNT_W:0]    credit_used;
  logic              credit_ok;
  logic              seq_req;

  //////////////////////////////////////////////////////////////////////
  // Credit
  //////////////////////////////////////////////////////////////////////

  // Slots in use: words buffered plus reads still in flight
  assign credit_used = {1'b0, buf_count_i} + {1'b0, outstanding_cnt_i};
  assign credit_ok   = credit_used < (CNT_W + 1)'(FIFO_DEPTH);

  // Sequential read needs enable, a started stream and a free slot
  assign seq_req = fetch_en_i && started_q && credit_ok;

  //////////////////////////////////////////////////////////////////////
  // Request select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Default is the next sequential word
    bus_req_o.addr  = last_addr_q + ADDR_W'(4);
    bus_req_valid_o = 1'b0;
    if (branch_i) begin
      // Branch goes straight out, no enable or credit check
      bus_req_valid_o = 1'b1;
      bus_req_o.addr  = branch_addr_i;
    end else if (state_q == BRANCH_WAIT) begin
      // Keep presenting the stalled branch target
      bus_req_valid_o = 1'b1;
      bus_req_o.addr  = held_addr_q;
    end else begin
      bus_req_valid_o = seq_req;
    end
  end

  assign req_fire_o = bus_req_valid_o && bus_req_ready_i;
  // Any branch discards the old stream
  assign flush_o    = branch_i;

  // Next state
  always_comb begin
    state_d = state_q;
    if (branch_i) begin
      state_d = bus_req_ready_i ? IDLE : BRANCH_WAIT;
    end else if ((state_q == BRANCH_WAIT) && bus_req_ready_i) begin
      state_d = IDLE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      started_q   <= 1'b0;
      last_addr_q <= '0;
    end else begin
      state_q <= state_d;
      // First branch after reset opens the stream
      if (branch_i) begin
        started_q <= 1'b1;
      end
      if (req_fire_o) begin
        last_addr_q <= bus_req_o.addr;
      end
    end
  end

  // Branch target, only read back in BRANCH_WAIT
  always_ff @(posedge clk) begin
    if (branch_i) begin
      held_addr_q <= branch_addr_i;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the prefetch unit testbench with Verilator and runs it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_prefetch_unit -f compile.f -o sim_prefetch; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_prefetch
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0

// ==== source/bus_resp_tracker.sv ====
/*
 * Tracks reads in flight on the instruction bus. Pairs each response
 * with its request address and drops responses of reads issued
 * before a branch, so only the live stream reaches the buffer.
 */
`timescale 1ns/10ps

module bus_resp_tracker import fetch_pkg::*, bus_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int CNT_W      = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // Accepted request
  input  logic              req_fire_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic              flush_i,
  // Bus response, in request order
  input  logic              bus_rsp_valid_i,
  input  bus_rsp_t          bus_rsp_i,
  // Credit and kept responses
  output logic [CNT_W-1:0]  outstanding_cnt_o,
  output logic              rsp_valid_o,
  output fetch_out_t        rsp_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [ADDR_W-1:0] addr_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  out_cnt_q;
  logic [CNT_W-1:0]  discard_q;
  logic              drop;

  //////////////////////////////////////////////////////////////////////
  // Response filter
  //////////////////////////////////////////////////////////////////////

  // Old-stream response, either pending discard or arriving on a flush
  assign drop        = bus_rsp_valid_i && (flush_i || (discard_q != '0));
  assign rsp_valid_o = bus_rsp_valid_i && !drop;
  assign rsp_o.addr  = addr_mem[rd_ptr_q];
  assign rsp_o.instr = bus_rsp_i.rdata;

  assign outstanding_cnt_o = out_cnt_q;

  // Address queue holds only reads of the live stream
  always_ff @(posedge clk) begin
    if (req_fire_i) begin
      addr_mem[wr_ptr_q] <= req_addr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      out_cnt_q <= '0;
      discard_q <= '0;
    end else begin
      // All accepted reads count, dropped or not
      out_cnt_q <= out_cnt_q + CNT_W'(req_fire_i) - CNT_W'(bus_rsp_valid_i);
      if (req_fire_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (flush_i) begin
        // Everything in flight before the branch read is stale
        discard_q <= out_cnt_q - CNT_W'(bus_rsp_valid_i);
        // Branch read, if accepted now, lands at the old write pointer
        rd_ptr_q  <= wr_ptr_q;
      end else begin
        if (drop) begin
          discard_q <= discard_q - 1'b1;
        end
        if (rsp_valid_o) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/prefetch_unit.sv ====
/*
 * Instruction prefetch unit top level.
 * Joins the request FSM, the response tracker and the prefetch FIFO.
 * FIFO_DEPTH sets buffer size and the read credit limit.
 */
`timescale 1ns/10ps

module prefetch_unit import fetch_pkg::*, bus_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // Fetch stage
  input  logic              fetch_en_i,
  input  logic              branch_i,
  input  logic [ADDR_W-1:0] branch_addr_i,
  output logic              instr_valid_o,
  input  logic              instr_ready_i,
  output fetch_out_t        instr_o,
  // Instruction bus
  output logic              bus_req_valid_o,
  input  logic              bus_req_ready_i,
  output bus_req_t          bus_req_o,
  input  logic              bus_rsp_valid_i,
  input  bus_rsp_t          bus_rsp_i
);

  // Counts reach past FIFO_DEPTH while stale reads drain
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1) + 1;

  logic             req_fire;
  logic             flush;
  logic [CNT_W-1:0] outstanding_cnt;
  logic [CNT_W-1:0] buf_count;
  logic             rsp_keep_valid;
  fetch_out_t       rsp_keep;

  prefetch_controller #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) ctrl0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_en_i        (fetch_en_i),
    .branch_i          (branch_i),
    .branch_addr_i     (branch_addr_i),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_req_o         (bus_req_o),
    .outstanding_cnt_i (outstanding_cnt),
    .buf_count_i       (buf_count),
    .req_fire_o        (req_fire),
    .flush_o           (flush)
  );

  bus_resp_tracker #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) trk0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_fire_i        (req_fire),
    .req_addr_i        (bus_req_o.addr),
    .flush_i           (flush),
    .bus_rsp_valid_i   (bus_rsp_valid_i),
    .bus_rsp_i         (bus_rsp_i),
    .outstanding_cnt_o (outstanding_cnt),
    .rsp_valid_o       (rsp_keep_valid),
    .rsp_o             (rsp_keep)
  );

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) buf0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush),
    .wr_valid_i (rsp_keep_valid),
    .wr_data_i  (rsp_keep),
    .rd_valid_o (instr_valid_o),
    .rd_ready_i (instr_ready_i),
    .rd_data_o  (instr_o),
    .count_o    (buf_count)
  );

endmodule

// ==== test/tb_bus_model.sv ====
/*
 * Instruction bus slave for the prefetch testbench. Accepts reads with
 * random stalls, answers each one in order with the inverted address.
 */
`timescale 1ns/10ps

module tb_bus_model import bus_pkg::*; #(
  parameter int SEED = 14
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  bus_req_t req_i,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o
);

  integer      seed = SEED;
  logic [31:0] pending [$];
  int          gap;

  // Accepted read addresses, oldest first
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending.delete();
    end else if (req_valid_i && req_ready_o) begin
      pending.push_back(req_i.addr);
    end
  end

  // Ready and responses change on the falling edge
  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    gap         = 0;
    forever begin
      @(negedge clk);
      rsp_valid_o = 1'b0;
      if (!rst_n) begin
        req_ready_o = 1'b0;
        gap         = 0;
      end else begin
        // Stall roughly one cycle in four
        req_ready_o = ($unsigned($random(seed)) % 4) != 0;
        if (gap != 0) begin
          gap = gap - 1;
        end else if (pending.size() != 0) begin
          rsp_valid_o = 1'b1;
          rsp_o.rdata = ~pending.pop_front();
          // Idle cycles before the next response
          gap         = $unsigned($random(seed)) % 4;
        end
      end
    end
  end

endmodule

// ==== test/tb_prefetch_unit.sv ====
/*
 * Testbench for the instruction prefetch unit. Drives branches, fetch
 * enable and fetch back-pressure against a random bus model; all
 * request and instruction checks are concurrent assertions.
 */
`timescale 1ns/10ps

module tb_prefetch_unit import fetch_pkg::*, bus_pkg::*; ();

  localparam int SEED    = 14;
  localparam int TIMEOUT = 2000;

  logic        clk;
  logic        rst_n;
  logic        fetch_en;
  logic        branch;
  logic [31:0] branch_addr;
  logic        instr_valid;
  logic        instr_ready;
  fetch_out_t  instr;
  logic        bus_req_valid;
  logic        bus_req_ready;
  bus_req_t    bus_req;
  logic        bus_rsp_valid;
  bus_rsp_t    bus_rsp;
  integer      seed = SEED;

  // Reference model state
  logic        started;
  logic        pend;
  logic [31:0] pend_addr;
  logic [31:0] last_acc;
  logic [31:0] exp_addr;
  int          delivered;
  logic        req_fire;
  logic        instr_fire;

  assign req_fire   = bus_req_valid && bus_req_ready;
  assign instr_fire = instr_valid && instr_ready;

  prefetch_unit #(.FIFO_DEPTH(4)) dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_en_i      (fetch_en),
    .branch_i        (branch),
    .branch_addr_i   (branch_addr),
    .instr_valid_o   (instr_valid),
    .instr_ready_i   (instr_ready),
    .instr_o         (instr),
    .bus_req_valid_o (bus_req_valid),
    .bus_req_ready_i (bus_req_ready),
    .bus_req_o       (bus_req),
    .bus_rsp_valid_i (bus_rsp_valid),
    .bus_rsp_i       (bus_rsp)
  );

  tb_bus_model #(.SEED(SEED)) bus0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (bus_req_valid),
    .req_ready_o (bus_req_ready),
    .req_i       (bus_req),
    .rsp_valid_o (bus_rsp_valid),
    .rsp_o       (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_error($sformatf("mismatch at %0t: %s", $time, msg));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model stepped on each rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started   <= 1'b0;
      pend      <= 1'b0;
      pend_addr <= '0;
      last_acc  <= '0;
      exp_addr  <= '0;
      delivered <= 0;
    end else begin
      if (branch) begin
        started   <= 1'b1;
        // Branch target waits while the bus stalls
        pend      <= !bus_req_ready;
        pend_addr <= branch_addr;
        exp_addr  <= branch_addr;
      end else begin
        if (bus_req_ready) begin
          pend <= 1'b0;
        end
        if (instr_fire) begin
          exp_addr <= exp_addr + 32'd4;
        end
      end
      if (req_fire) begin
        last_acc <= bus_req.addr;
      end
      if (instr_fire) begin
        delivered <= delivered + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  a_branch_pass: assert property (@(posedge clk) disable iff (!rst_n)
    branch |-> bus_req_valid && bus_req.addr == branch_addr)
    else report_mismatch("branch target not passed to the bus");
  a_branch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pend && !branch |-> bus_req_valid && bus_req.addr == pend_addr)
    else report_mismatch("stalled branch target not held");
  a_seq_incr: assert property (@(posedge clk) disable iff (!rst_n)
    req_fire && !branch && !pend |-> bus_req.addr == last_acc + 32'd4)
    else report_mismatch("sequential request is not previous address plus 4");
  a_align: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid |-> !bus_req.addr[0])
    else report_mismatch("request address not halfword aligned");
  a_first_branch: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> (!bus_req_valid || branch) && !instr_valid)
    else report_mismatch("activity before the first branch");
  a_fetch_en: assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_en && !branch && !pend |-> !bus_req_valid)
    else report_mismatch("sequential request while fetch disabled");
  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    instr_fire |-> instr.instr == ~instr.addr && instr.addr == exp_addr)
    else report_mismatch($sformatf("word at %h, expected %h", instr.addr, exp_addr));
  a_stable: assert property (@(posedge clk) disable iff (!rst_n)
    $past(instr_valid && !instr_ready && !branch) |-> instr_valid && $stable(instr))
    else report_mismatch("instruction output changed while stalled");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic take_branch(input logic [31:0] target);
    @(negedge clk);
    branch      = 1'b1;
    branch_addr = target;
    @(negedge clk);
    branch      = 1'b0;
  endtask

  // Waits for n delivered words with random ready and enable
  task automatic stream_words(input int n, input int ready_pct, input bit toggle_en);
    int start;
    int cycles;
    start  = delivered;
    cycles = 0;
    while (delivered < start + n) begin
      @(negedge clk);
      instr_ready = ($unsigned($random(seed)) % 100) < ready_pct;
      fetch_en    = !toggle_en || (($unsigned($random(seed)) % 8) != 0);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_error("timeout, instruction words stopped arriving");
      end
    end
  endtask

  initial begin
    int          i;
    int          n;
    logic [31:0] target;
    rst_n       = 1'b0;
    fetch_en    = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    instr_ready = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // No stream before a branch even when enabled and ready
    fetch_en    = 1'b1;
    instr_ready = 1'b1;
    repeat (8) @(negedge clk);
    // Random branches with some back to back
    for (i = 0; i < 40; i++) begin
      target = $random(seed) & 32'hffff_fffe;
      n      = $unsigned($random(seed)) % 12;
      take_branch(target);
      stream_words(n, 70, 1'b1);
    end
    // Stream resumes without a gap after each long fetch stall
    take_branch(32'h0000_1002);
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      instr_ready = 1'b0;
      fetch_en    = 1'b1;
      repeat (20) @(negedge clk);
      stream_words(6, 100, 1'b0);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule
